// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_crc_subsystem
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_TEXT ?= TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_crc_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_crc_subsystem;

	import crc_pkg::*;

	// words per test, worst case, times 40 cycles each
	localparam int max_cycles = (5 + 6 * 64 + 4 * 24 + 20 + 32) * 40 + 2000;

	logic clk, rst, wr_en, start_a, start_b;
	logic [addr_w-1:0] wr_addr, base_a, base_b;
	logic [data_w-1:0] wr_data;
	logic [len_w-1:0] len_a, len_b;
	logic busy_a, done_a, busy_b, done_b;
	logic [crc_w-1:0] crc_a, crc_b;

	logic [data_w-1:0] shadow [mem_depth]; // what the ram should hold
	logic [31:0] lfsr = 32'h1d1189c4;
	logic [crc_w-1:0] exp_a, exp_b; // expected crc of the running job
	int want_a = 0, want_b = 0; // done pulses expected so far
	int done_cnt_a = 0, done_cnt_b = 0;
	int check_cnt = 0, err_cnt = 0, test_num = 0, cycle_cnt = 0;
	logic [addr_w-1:0] ba, bb;
	logic [len_w-1:0] la, lb;

	crc_subsystem uut (
		.clk(clk), .rst(rst), .wr_en(wr_en), .start_a(start_a), .start_b(start_b),
		.wr_addr(wr_addr), .base_a(base_a), .base_b(base_b), .wr_data(wr_data),
		.len_a(len_a), .len_b(len_b), .busy_a(busy_a), .done_a(done_a),
		.busy_b(busy_b), .done_b(done_b), .crc_a(crc_a), .crc_b(crc_b)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// crc-16 poly 1021, init zero, msb first, words chained upward
	function automatic logic [15:0] crc_ref(input logic [5:0] base, input logic [6:0] len);
		logic [15:0] c;
		logic [5:0] a;
		logic [31:0] w;
		logic fb;
		c = 16'h0000;
		a = base;
		for (int n = 0; n < int'(len); n++) begin
			w = shadow[a];
			for (int i = 31; i >= 0; i--) begin
				fb = c[15] ^ w[i];
				c = {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
			end
			a = a + 6'd1; // wraps at 64
		end
		return c;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_cnt++;
		if (expected !== actual) begin
			err_cnt++;
			$display("FAIL %s expected %h got %h", name, expected, actual);
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		$display("test %0d %s finished, %0d errors so far", test_num, name, err_cnt);
	endtask

	task automatic host_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
		@(negedge clk);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		shadow[addr] = data;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic launch(input logic go_a, input logic go_b);
		@(negedge clk);
		start_a = go_a;
		base_a = ba;
		len_a = la;
		start_b = go_b;
		base_b = bb;
		len_b = lb;
		if (go_a) begin
			exp_a = crc_ref(ba, la);
			want_a++;
		end
		if (go_b) begin
			exp_b = crc_ref(bb, lb);
			want_b++;
		end
		@(negedge clk);
		start_a = 1'b0; // single-cycle start
		start_b = 1'b0;
	endtask

	task automatic wait_jobs;
		while (done_cnt_a < want_a || done_cnt_b < want_b) @(negedge clk);
	endtask

	// crc sampled mid-cycle while done is high
	always @(negedge clk) begin
		if (done_a) begin
			check_value("crc_a", {16'h0, exp_a}, {16'h0, crc_a});
			done_cnt_a++;
		end
		if (done_b) begin
			check_value("crc_b", {16'h0, exp_b}, {16'h0, crc_b});
			done_cnt_b++;
		end
	end

	initial begin
		while (cycle_cnt < max_cycles) @(posedge clk) cycle_cnt++;
		$display("timeout: jobs did not finish within %0d cycles", max_cycles);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		rst = 1'b1;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		start_a = 1'b0;
		start_b = 1'b0;
		base_a = '0;
		base_b = '0;
		len_a = '0;
		len_b = '0;
		ba = '0;
		bb = '0;
		la = '0;
		lb = '0;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_value("busy_a", 32'h0, {31'h0, busy_a});
		check_value("busy_b", 32'h0, {31'h0, busy_b});
		check_value("done_a", 32'h0, {31'h0, done_a});
		check_value("done_b", 32'h0, {31'h0, done_b});
		check_value("crc_a", 32'h0, {16'h0, crc_a});
		check_value("crc_b", 32'h0, {16'h0, crc_b});
		end_test("reset values");
		for (int i = 0; i < mem_depth; i++) begin
			host_write(addr_w'(i), rand_bits(32)); // fill every word
		end
		host_write(6'd0, 32'hdeadbeef); // known word
		ba = 6'd0;
		la = 7'd1;
		launch(1'b1, 1'b0);
		wait_jobs();
		for (int i = 0; i < 4; i++) begin
			ba = addr_w'(rand_bits(6));
			host_write(ba, rand_bits(32));
			launch(1'b1, 1'b0);
			wait_jobs();
		end
		end_test("single word on channel a");
		for (int i = 0; i < 6; i++) begin
			bb = addr_w'(rand_bits(6));
			lb = len_w'(rand_bits(6)) + 7'd1; // 1..64
			launch(1'b0, 1'b1);
			wait_jobs();
		end
		end_test("multi word on channel b");
		ba = addr_w'(rand_bits(6));
		la = len_w'(rand_bits(4)) + 7'd8;
		bb = ba + addr_w'(rand_bits(2)) + 6'd1; // starts inside a's range
		lb = len_w'(rand_bits(4)) + 7'd8;
		launch(1'b1, 1'b1);
		wait_jobs();
		bb = ba; // identical range
		lb = la;
		launch(1'b1, 1'b1);
		wait_jobs();
		check_value("crc_b", {16'h0, exp_a}, {16'h0, crc_b}); // same range as a
		end_test("both channels together");
		la = 7'd0;
		launch(1'b1, 1'b0);
		wait_jobs();
		ba = addr_w'(rand_bits(6));
		la = 7'd20;
		launch(1'b1, 1'b0);
		repeat (10) @(negedge clk);
		check_value("busy_a", 32'h1, {31'h0, busy_a}); // job still running
		start_a = 1'b1; // must be ignored
		base_a = ba + 6'd5;
		len_a = 7'd3;
		@(negedge clk);
		start_a = 1'b0;
		wait_jobs();
		end_test("zero length and start while busy");
		ba = 6'd0;
		la = 7'd16;
		bb = 6'd16;
		lb = 7'd16;
		launch(1'b1, 1'b1);
		for (int i = 0; i < 40; i++) begin
			host_write(6'd32 + addr_w'(rand_bits(5)), rand_bits(32)); // upper half only
			repeat (rand_bits(3)) @(negedge clk);
		end
		wait_jobs();
		end_test("host writes during jobs");
		$display("tests %0d, checks %0d, errors %0d", test_num, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/crc_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_engine (
	input wire logic clk,
	input wire logic rst,
	input wire logic crc_clear,
	input wire logic word_load,
	input wire logic [crc_pkg::data_w-1:0] word_in,
	output logic word_busy,
	output logic word_done,
	output logic [crc_pkg::crc_w-1:0] crc_out
);

	import crc_pkg::*;

	engine_state_t state;
	logic [bit_cnt_w-1:0] bit_cnt; // shifts done in this word
	logic [data_w-1:0] word_sh; // msb is next bit in
	logic [crc_w-1:0] crc_reg; // running remainder
	logic [crc_w-1:0] crc_shl;
	logic [crc_w-1:0] crc_next;
	logic feedback;

	// one step of the serial divider, msb first
	assign feedback = crc_reg[crc_w-1] ^ word_sh[data_w-1];
	assign crc_shl = {crc_reg[crc_w-2:0], 1'b0};
	assign crc_next = feedback ? (crc_shl ^ crc_poly) : crc_shl;

	assign word_busy = (state == eng_shift);
	assign word_done = (state == eng_done); // one cycle after last shift
	assign crc_out = crc_reg;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= eng_idle;
			bit_cnt <= '0;
			crc_reg <= '0;
		end else begin
			case (state)
				eng_idle: begin
					bit_cnt <= '0;
					if (word_load) begin
						state <= eng_shift; // 32 shift cycles follow
					end
				end
				eng_shift: begin
					crc_reg <= crc_next;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == {bit_cnt_w{1'b1}}) begin
						state <= eng_done; // 32nd bit folded in
					end
				end
				eng_done: begin
					state <= eng_idle;
				end
				default: begin
					state <= eng_idle;
				end
			endcase
			// new job starts from zero remainder
			if (crc_clear) begin
				crc_reg <= '0;
			end
		end
	end

	// word shift register
	always_ff @(posedge clk) begin
		if (word_load && state == eng_idle) begin
			word_sh <= word_in; // capture on load edge
		end else if (state == eng_shift) begin
			word_sh <= {word_sh[data_w-2:0], 1'b0}; // next bit to msb
		end
	end

endmodule

`default_nettype wire

// ==== hdl/crc_job_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_job_ctrl (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire logic rd_gnt,
	input wire logic [crc_pkg::addr_w-1:0] base,
	input wire logic [crc_pkg::len_w-1:0] len,
	input wire logic [crc_pkg::data_w-1:0] rd_data,
	input wire logic word_busy,
	input wire logic word_done,
	output logic busy,
	output logic done,
	output logic rd_req,
	output logic crc_clear,
	output logic word_load,
	output logic [crc_pkg::addr_w-1:0] rd_addr,
	output logic [crc_pkg::data_w-1:0] word_in
);

	import crc_pkg::*;

	job_state_t state;
	logic [addr_w-1:0] addr_q; // current word, wraps mod 64
	logic [len_w-1:0] remain; // words still to fold
	logic [data_w-1:0] word_q;
	logic load_q;
	logic accept;

	// start only counts with channel and engine both quiet
	assign accept = start && (state == job_idle) && !word_busy;

	assign busy = (state != job_idle);
	assign done = (state == job_finish);
	assign rd_req = (state == job_req); // held until grant
	assign rd_addr = addr_q;
	assign crc_clear = accept; // zero remainder as job begins
	assign word_load = load_q;
	assign word_in = word_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= job_idle;
			remain <= '0;
			load_q <= 1'b0;
		end else begin
			load_q <= 1'b0; // single-cycle pulse
			case (state)
				job_idle: begin
					if (accept) begin
						remain <= len;
						// empty job finishes right away
						state <= (len == '0) ? job_finish : job_req;
					end
				end
				job_req: begin
					if (rd_gnt) begin
						state <= job_wait; // ram answers next cycle
					end
				end
				job_wait: begin
					load_q <= 1'b1; // word_q valid next cycle
					state <= job_crunch;
				end
				job_crunch: begin
					if (word_done) begin
						remain <= remain - 1'b1;
						state <= (remain == 1) ? job_finish : job_req;
					end
				end
				job_finish: begin
					state <= job_idle;
				end
				default: begin
					state <= job_idle;
				end
			endcase
		end
	end

	// address and word holding registers
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= base;
		end else if (state == job_crunch && word_done) begin
			addr_q <= addr_q + 1'b1; // next word, chained in order
		end
		if (state == job_wait) begin
			word_q <= rd_data; // shared read bus, ours this cycle
		end
	end

endmodule

`default_nettype wire

// ==== hdl/crc_pkg.sv ====
`default_nettype none

package crc_pkg;

	// datapath widths
	localparam int data_w = 32; // one memory word
	localparam int crc_w = 16; // remainder width

	// generator polynomial, x^16 term implied
	localparam logic [crc_w-1:0] crc_poly = 16'h1021;

	// shared word memory
	localparam int addr_w = 6; // 64 words
	localparam int mem_depth = 64;

	// job length counts 0..64 inclusive
	localparam int len_w = 7;

	// engine bit counter, 0..31
	localparam int bit_cnt_w = 5;

	typedef enum logic [1:0] {
		eng_idle, // waiting for word_load
		eng_shift, // one bit per cycle
		eng_done // word_done cycle
	} engine_state_t;

	typedef enum logic [2:0] {
		job_idle, // waiting for start
		job_req, // rd_req held until grant
		job_wait, // memory data arrives here
		job_crunch, // engine folding the word
		job_finish // done pulse
	} job_state_t;

endpackage

`default_nettype wire

// ==== hdl/crc_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_subsystem (
	input wire logic clk,
	input wire logic rst,
	input wire logic wr_en,
	input wire logic start_a,
	input wire logic start_b,
	input wire logic [crc_pkg::addr_w-1:0] wr_addr,
	input wire logic [crc_pkg::addr_w-1:0] base_a,
	input wire logic [crc_pkg::addr_w-1:0] base_b,
	input wire logic [crc_pkg::data_w-1:0] wr_data,
	input wire logic [crc_pkg::len_w-1:0] len_a,
	input wire logic [crc_pkg::len_w-1:0] len_b,
	output logic busy_a,
	output logic done_a,
	output logic busy_b,
	output logic done_b,
	output logic [crc_pkg::crc_w-1:0] crc_a,
	output logic [crc_pkg::crc_w-1:0] crc_b
);

	import crc_pkg::*;

	// channel a, controller to engine and arbiter
	logic rd_req_a, gnt_a, clear_a, load_a, wbusy_a, wdone_a;
	logic [addr_w-1:0] rd_addr_a;
	logic [data_w-1:0] word_a;

	// channel b
	logic rd_req_b, gnt_b, clear_b, load_b, wbusy_b, wdone_b;
	logic [addr_w-1:0] rd_addr_b;
	logic [data_w-1:0] word_b;

	// single ram port
	logic mem_en, mem_we;
	logic [addr_w-1:0] mem_addr;
	logic [data_w-1:0] mem_wdata;
	logic [data_w-1:0] mem_rdata; // fans out to both channels

	crc_job_ctrl u_ctrl_a (
		.clk(clk), .rst(rst), .start(start_a), .rd_gnt(gnt_a),
		.base(base_a), .len(len_a), .rd_data(mem_rdata),
		.word_busy(wbusy_a), .word_done(wdone_a),
		.busy(busy_a), .done(done_a), .rd_req(rd_req_a),
		.crc_clear(clear_a), .word_load(load_a),
		.rd_addr(rd_addr_a), .word_in(word_a)
	);

	crc_engine u_eng_a (
		.clk(clk), .rst(rst), .crc_clear(clear_a), .word_load(load_a),
		.word_in(word_a), .word_busy(wbusy_a), .word_done(wdone_a),
		.crc_out(crc_a)
	);

	crc_job_ctrl u_ctrl_b (
		.clk(clk), .rst(rst), .start(start_b), .rd_gnt(gnt_b),
		.base(base_b), .len(len_b), .rd_data(mem_rdata),
		.word_busy(wbusy_b), .word_done(wdone_b),
		.busy(busy_b), .done(done_b), .rd_req(rd_req_b),
		.crc_clear(clear_b), .word_load(load_b),
		.rd_addr(rd_addr_b), .word_in(word_b)
	);

	crc_engine u_eng_b (
		.clk(clk), .rst(rst), .crc_clear(clear_b), .word_load(load_b),
		.word_in(word_b), .word_busy(wbusy_b), .word_done(wdone_b),
		.crc_out(crc_b)
	);

	mem_arbiter u_arb (
		.clk(clk), .rst(rst), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.req_a(rd_req_a), .req_b(rd_req_b), .addr_a(rd_addr_a), .addr_b(rd_addr_b),
		.gnt_a(gnt_a), .gnt_b(gnt_b), .mem_en(mem_en), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	word_ram u_ram (
		.clk(clk), .en(mem_en), .we(mem_we), .addr(mem_addr),
		.wdata(mem_wdata), .rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input wire logic clk,
	input wire logic rst,
	input wire logic wr_en,
	input wire logic [crc_pkg::addr_w-1:0] wr_addr,
	input wire logic [crc_pkg::data_w-1:0] wr_data,
	input wire logic req_a,
	input wire logic req_b,
	input wire logic [crc_pkg::addr_w-1:0] addr_a,
	input wire logic [crc_pkg::addr_w-1:0] addr_b,
	output logic gnt_a,
	output logic gnt_b,
	output logic mem_en,
	output logic mem_we,
	output logic [crc_pkg::addr_w-1:0] mem_addr,
	output logic [crc_pkg::data_w-1:0] mem_wdata
);

	import crc_pkg::*;

	logic last_a; // a was served most recently
	logic pick_a;

	// a wins when alone, or when b went last
	assign pick_a = req_a && (!req_b || !last_a);

	// host write owns the port, channels wait
	assign gnt_a = !wr_en && pick_a;
	assign gnt_b = !wr_en && req_b && !pick_a;

	assign mem_en = wr_en || gnt_a || gnt_b;
	assign mem_we = wr_en;
	assign mem_wdata = wr_data; // only sampled on writes

	always_comb begin
		if (wr_en) begin
			mem_addr = wr_addr;
		end else if (gnt_b) begin
			mem_addr = addr_b;
		end else begin
			mem_addr = addr_a; // also idle default
		end
	end

	// round-robin history
	always_ff @(posedge clk) begin
		if (rst) begin
			last_a <= 1'b0; // a first after reset
		end else if (gnt_a) begin
			last_a <= 1'b1;
		end else if (gnt_b) begin
			last_a <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/word_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_ram (
	input wire logic clk,
	input wire logic en,
	input wire logic we,
	input wire logic [crc_pkg::addr_w-1:0] addr,
	input wire logic [crc_pkg::data_w-1:0] wdata,
	output logic [crc_pkg::data_w-1:0] rdata
);

	import crc_pkg::*;

	logic [data_w-1:0] mem [mem_depth]; // 64 x 32 storage

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata; // rdata keeps last read
			end else begin
				rdata <= mem[addr]; // one cycle latency
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/crc_pkg.sv
hdl/crc_engine.sv
hdl/crc_job_ctrl.sv
hdl/mem_arbiter.sv
hdl/word_ram.sv
hdl/crc_subsystem.sv
bench/tb_crc_subsystem.sv
